/* files.f */
+incdir+verification
verilog/eth_tx_pkg.sv
verilog/ip_header_checksum.sv
verilog/payload_buffer.sv
verilog/ip_tx.sv
verilog/mac_tx_crc.sv
verilog/eth_tx_top.sv
verification/eth_tx_tb.sv

/* verification/eth_tx_ref.svh */
// reference models: lfsr step, ipv4 header checksum, crc-32 byte update, expected frame byte
`ifndef ETH_TX_REF_SVH
`define ETH_TX_REF_SVH

// fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

// ones' complement sum of the ten header words, checksum word as zero
function automatic logic [15:0] header_checksum(input eth_tx_pkg::ip_tx_cfg_t c,
                                                input logic [15:0] total);
  logic [31:0] sum;
  sum = 32'h4500 + total + c.ident + 32'h4000 + {c.ttl, c.protocol}
      + c.src_ip[31:16] + c.src_ip[15:0] + c.dst_ip[31:16] + c.dst_ip[15:0];
  while (sum[31:16] != 16'h0000)
    sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
  return ~sum[15:0];
endfunction

// reflected crc-32, one data bit per step
function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] b);
  logic [31:0] c;
  logic        fb;
  c = crc;
  for (int i = 0; i < 8; i++)
  begin
    fb = c[0] ^ b[i];
    c  = c >> 1;
    if (fb)
      c = c ^ 32'hEDB88320;
  end
  return c;
endfunction

// frame byte idx counted from the destination mac
function automatic logic [7:0] expected_byte(input eth_tx_pkg::ip_tx_cfg_t c,
                                             input logic [15:0] total, input int idx,
                                             input logic [7:0] pay_byte);
  logic [271:0] hdr;
  hdr = {c.dst_mac, c.src_mac, 16'h0800, 8'h45, 8'h00, total, c.ident, 16'h4000,
         c.ttl, c.protocol, header_checksum(c, total), c.src_ip, c.dst_ip};
  if (idx < 34)
    return hdr[271 - 8 * idx -: 8];
  else if (idx - 34 < int'(total) - 20)
    return pay_byte;
  else
    return 8'h00;
endfunction

`endif

/* verification/eth_tx_tb.sv */
// testbench top with clock, reset, payload and frame stimulus, gmii monitor, checks, timeout and report
`timescale 1ns/1ps

module eth_tx_tb;

  `include "eth_tx_ref.svh"

  localparam int num_frames = 5;
  localparam int max_cycles = 2000 * num_frames;

  logic                   clk;
  logic                   rst_n;
  eth_tx_pkg::ip_tx_cfg_t cfg;
  logic [15:0]            payload_len;
  logic                   wr_en;
  logic [7:0]             wr_data;
  logic                   tx_start;
  logic                   gmii_tx_en;
  logic [7:0]             gmii_txd;
  logic                   busy;

  logic [15:0] lfsr;
  logic [7:0]  pay [64];
  logic [7:0]  cur_q [$];
  logic [7:0]  last_q [$];
  int          frames_seen;
  int          cycles;
  int          checks;
  int          errors;
  int          tests;
  int          failed;

  eth_tx_top #(
    .PAYLOAD_DEPTH (64)
  ) eth_tx_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg),
    .payload_len (payload_len),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .tx_start    (tx_start),
    .gmii_tx_en  (gmii_tx_en),
    .gmii_txd    (gmii_txd),
    .busy        (busy)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // gmii monitor and run limit
  ////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    if (gmii_tx_en)
      cur_q.push_back(gmii_txd);
    else if (cur_q.size() != 0)
    begin
      last_q = cur_q;
      cur_q.delete();
      frames_seen++;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("timeout after %0d cycles, a frame never completed", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [63:0] next_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic eth_tx_pkg::ip_tx_cfg_t random_cfg();
    eth_tx_pkg::ip_tx_cfg_t c;
    logic [63:0]            v;
    v = next_bits(48);
    c.dst_mac = v[47:0];
    v = next_bits(48);
    c.src_mac = v[47:0];
    v = next_bits(32);
    c.src_ip = v[31:0];
    v = next_bits(32);
    c.dst_ip = v[31:0];
    v = next_bits(32);
    c.ttl      = v[7:0];
    c.protocol = v[15:8];
    c.ident    = v[31:16];
    return c;
  endfunction

  task automatic compare_byte(input string what, input int idx, input logic [7:0] want,
                              input logic [7:0] got);
    checks++;
    assert (got === want)
    else
    begin
      $display("[FAIL] gmii_txd %s byte %0d: expected %h, got %h", what, idx, want, got);
      errors++;
    end
  endtask

  task automatic compare_level(input string name, input logic want, input logic got);
    checks++;
    assert (got === want)
    else
    begin
      $display("[FAIL] %s: expected %h, got %h", name, want, got);
      errors++;
    end
  endtask

  task automatic load_payload(input int n);
    logic [63:0] v;
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk);
      v       = next_bits(8);
      pay[i]  = v[7:0];
      wr_en   <= 1'b1;
      wr_data <= pay[i];
    end
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic start_frame(input eth_tx_pkg::ip_tx_cfg_t c, input logic [15:0] len);
    @(posedge clk);
    cfg         <= c;
    payload_len <= len;
    tx_start    <= 1'b1;
    @(posedge clk);
    tx_start <= 1'b0;
  endtask

  // new cfg, start strobe and writes issued while busy
  task automatic poke_while_busy();
    @(posedge clk);
    cfg      <= random_cfg();
    tx_start <= 1'b1;
    wr_en    <= 1'b1;
    wr_data  <= 8'hA5;
    @(posedge clk);
    tx_start <= 1'b0;
    wr_data  <= 8'h3C;
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic check_frame(input eth_tx_pkg::ip_tx_cfg_t c, input logic [15:0] len);
    logic [15:0] total;
    logic [31:0] crc;
    logic [7:0]  want;
    int          frame_len;
    bit          len_ok;
    total     = len + 16'd20;
    frame_len = 14 + ((total < 16'd46) ? 46 : int'(total));
    len_ok    = (last_q.size() == 8 + frame_len + 4);
    checks++;
    assert (len_ok)
    else
    begin
      $display("[FAIL] gmii_tx_en frame length: expected %h, got %h",
               8 + frame_len + 4, last_q.size());
      errors++;
    end
    if (len_ok)
    begin
      for (int i = 0; i < 7; i++)
        compare_byte("preamble", i, 8'h55, last_q[i]);
      compare_byte("sfd", 7, 8'hD5, last_q[7]);
      crc = 32'hFFFFFFFF;
      for (int i = 0; i < frame_len; i++)
      begin
        want = expected_byte(c, total, i, (i >= 34) ? pay[(i - 34) % 64] : 8'h00);
        crc  = crc32_step(crc, want);
        compare_byte("frame", i, want, last_q[8 + i]);
      end
      crc = ~crc;
      for (int j = 0; j < 4; j++)
        compare_byte("fcs", j, crc[8 * j +: 8], last_q[8 + frame_len + j]);
    end
  endtask

  task automatic run_frame(input string name, input int len, input bit poke);
    eth_tx_pkg::ip_tx_cfg_t c;
    int                     base;
    int                     errs_before;
    errs_before = errors;
    c = random_cfg();
    load_payload(len);
    base = frames_seen;
    start_frame(c, 16'(len));
    if (poke)
      poke_while_busy();
    @(negedge clk);
    compare_level("busy", 1'b1, busy);
    while (frames_seen == base)
      @(negedge clk);
    check_frame(c, 16'(len));
    compare_level("busy", 1'b0, busy);
    if (poke)
    begin
      repeat (150) @(negedge clk);
      checks++;
      assert ((frames_seen == base + 1) && !busy)
      else
      begin
        $display("a tx_start issued while busy produced a second frame");
        errors++;
      end
    end
    tests++;
    if (errors != errs_before)
      failed++;
    $display("test %-16s %s", name, (errors == errs_before) ? "pass" : "fail");
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cfg         = '0;
    payload_len = 16'd0;
    wr_en       = 1'b0;
    wr_data     = 8'h00;
    tx_start    = 1'b0;
    lfsr        = 16'd87;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    run_frame("long_payload", 40, 1'b0);
    run_frame("short_payload", 10, 1'b0);
    run_frame("ignored_strobes", 24, 1'b1);
    // second frame starts as soon as the first is checked
    run_frame("back_to_back_a", 33, 1'b0);
    run_frame("back_to_back_b", 17, 1'b0);
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* verilog/eth_tx_top.sv */
// eth_tx_top, ipv4 transmit path with payload buffer, framer and gmii mac
`timescale 1ns/1ps

module eth_tx_top
#(
  parameter int PAYLOAD_DEPTH = 64
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  eth_tx_pkg::ip_tx_cfg_t cfg,
  input  logic [15:0]            payload_len,
  input  logic                   wr_en,
  input  logic [7:0]             wr_data,
  input  logic                   tx_start,
  output logic                   gmii_tx_en,
  output logic [7:0]             gmii_txd,
  output logic                   busy
);

  logic       upper_tx_ready;
  logic [7:0] upper_layer_data;
  logic       upper_data_req;
  logic       mac_data_req;
  logic       ip_tx_ready;
  logic [7:0] ip_tx_data;
  logic       ip_tx_end;

  payload_buffer #(
    .PAYLOAD_DEPTH (PAYLOAD_DEPTH)
  ) payload_buffer_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .wr_en            (wr_en),
    .wr_data          (wr_data),
    .payload_len      (payload_len),
    .busy             (busy),
    .upper_data_req   (upper_data_req),
    .upper_tx_ready   (upper_tx_ready),
    .upper_layer_data (upper_layer_data)
  );

  // busy is the framer's own busy level
  ip_tx ip_tx_inst
  (
    .clk              (clk),
    .rst_n            (rst_n),
    .cfg              (cfg),
    .payload_len      (payload_len),
    .tx_start         (tx_start),
    .upper_tx_ready   (upper_tx_ready),
    .upper_layer_data (upper_layer_data),
    .upper_data_req   (upper_data_req),
    .mac_data_req     (mac_data_req),
    .ip_tx_busy       (busy),
    .ip_tx_ready      (ip_tx_ready),
    .ip_tx_data       (ip_tx_data),
    .ip_tx_end        (ip_tx_end)
  );

  mac_tx_crc mac_tx_crc_inst
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .ip_tx_ready  (ip_tx_ready),
    .ip_tx_data   (ip_tx_data),
    .ip_tx_end    (ip_tx_end),
    .mac_data_req (mac_data_req),
    .gmii_tx_en   (gmii_tx_en),
    .gmii_txd     (gmii_txd)
  );

endmodule

/* verilog/mac_tx_crc.sv */
// mac_tx_crc, gmii transmitter with preamble, delimiter, frame pass-through and crc-32 fcs
`timescale 1ns/1ps

module mac_tx_crc
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ip_tx_ready,
  input  logic [7:0] ip_tx_data,
  input  logic       ip_tx_end,
  output logic       mac_data_req,
  output logic       gmii_tx_en,
  output logic [7:0] gmii_txd
);

  // reflected form of 0x04c11db7
  localparam logic [31:0] crc_poly_rev  = 32'hEDB88320;
  localparam logic [7:0]  preamble_byte = 8'h55;
  localparam logic [7:0]  sfd_byte      = 8'hD5;

  eth_tx_pkg::mac_tx_state_e state;
  eth_tx_pkg::mac_tx_state_e state_next;

  logic [2:0]  cnt;
  logic        ready_d;
  logic [31:0] crc;

  // lsb first, one byte per call
  function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in, input logic [7:0] data);
    logic [31:0] c;
    c = crc_in ^ {24'h000000, data};
    for (int i = 0; i < 8; i++)
      c = c[0] ? ((c >> 1) ^ crc_poly_rev) : (c >> 1);
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    state_next = state;
    case (state)
      eth_tx_pkg::mac_idle:
        if (ip_tx_ready && !ready_d)
          state_next = eth_tx_pkg::mac_preamble;
      eth_tx_pkg::mac_preamble:
        if (cnt == 3'd7)
          state_next = eth_tx_pkg::mac_frame;
      eth_tx_pkg::mac_frame:
        if (ip_tx_end)
          state_next = eth_tx_pkg::mac_fcs;
      eth_tx_pkg::mac_fcs:
        if (cnt == 3'd3)
          state_next = eth_tx_pkg::mac_idle;
      default:
        state_next = eth_tx_pkg::mac_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= eth_tx_pkg::mac_idle;
      cnt          <= 3'd0;
      ready_d      <= 1'b0;
      mac_data_req <= 1'b0;
    end
    else
    begin
      state   <= state_next;
      cnt     <= (state_next != state) ? 3'd0 : cnt + 3'd1;
      ready_d <= ip_tx_ready;
      // framer needs two cycles, so byte 0 lands right after the sfd
      mac_data_req <= (state == eth_tx_pkg::mac_preamble) && (cnt == 3'd5);
    end
  end

  ////////////////////////////////////////////////////////////
  // gmii output and crc accumulator
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gmii_tx_en <= 1'b0;
      gmii_txd   <= 8'h00;
      crc        <= 32'hFFFFFFFF;
    end
    else
    begin
      case (state)
        eth_tx_pkg::mac_preamble:
        begin
          gmii_tx_en <= 1'b1;
          gmii_txd   <= (cnt == 3'd7) ? sfd_byte : preamble_byte;
          crc        <= 32'hFFFFFFFF;
        end
        eth_tx_pkg::mac_frame:
        begin
          gmii_tx_en <= 1'b1;
          gmii_txd   <= ip_tx_data;
          crc        <= crc32_byte(crc, ip_tx_data);
        end
        eth_tx_pkg::mac_fcs:
        begin
          // inverted remainder, low byte first
          gmii_tx_en <= 1'b1;
          gmii_txd   <= ~crc[7:0];
          crc        <= {8'h00, crc[31:8]};
        end
        default:
        begin
          gmii_tx_en <= 1'b0;
          gmii_txd   <= 8'h00;
          crc        <= 32'hFFFFFFFF;
        end
      endcase
    end
  end

endmodule

/* verilog/ip_tx.sv */
// ip_tx, ipv4 framer state machine with header byte multiplexer and checksum instance
`timescale 1ns/1ps

module ip_tx
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  eth_tx_pkg::ip_tx_cfg_t cfg,
  input  logic [15:0]            payload_len,
  input  logic                   tx_start,
  input  logic                   upper_tx_ready,
  input  logic [7:0]             upper_layer_data,
  output logic                   upper_data_req,
  input  logic                   mac_data_req,
  output logic                   ip_tx_busy,
  output logic                   ip_tx_ready,
  output logic [7:0]             ip_tx_data,
  output logic                   ip_tx_end
);

  eth_tx_pkg::ip_tx_state_e state;
  eth_tx_pkg::ip_tx_state_e state_next;
  eth_tx_pkg::ip_tx_cfg_t   cfg_q;

  logic [15:0]      total_len_q;
  logic [15:0]      ip_len_pad;
  logic [15:0]      last_idx;
  logic [15:0]      byte_cnt;
  logic [15:0]      timeout;
  logic [2:0]       wait_cnt;
  logic             checksum_start;
  logic             checksum_done;
  logic [15:0]      checksum;
  logic [33:0][7:0] hdr;
  logic [5:0]       hdr_idx;

  assign ip_len_pad = (total_len_q < eth_tx_pkg::min_ip_len) ? eth_tx_pkg::min_ip_len
                                                              : total_len_q;
  assign last_idx   = eth_tx_pkg::eth_hdr_len + ip_len_pad - 16'd1;
  assign ip_tx_busy = (state != eth_tx_pkg::ip_idle);

  // ethernet and ipv4 headers, first byte at the top
  assign hdr = {cfg_q.dst_mac, cfg_q.src_mac, eth_tx_pkg::eth_type_ipv4,
                eth_tx_pkg::ip_ver_ihl, 8'h00, total_len_q, cfg_q.ident,
                eth_tx_pkg::ip_flags_frag, cfg_q.ttl, cfg_q.protocol, checksum,
                cfg_q.src_ip, cfg_q.dst_ip};
  assign hdr_idx = 6'(eth_tx_pkg::eth_hdr_len + eth_tx_pkg::ip_hdr_len - 16'd1 - byte_cnt);

  ip_header_checksum ip_header_checksum_inst
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (checksum_start),
    .cfg       (cfg_q),
    .total_len (total_len_q),
    .checksum  (checksum),
    .done      (checksum_done)
  );

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    state_next = state;
    case (state)
      eth_tx_pkg::ip_idle:
        if (tx_start)
          state_next = eth_tx_pkg::ip_wait_length;
      eth_tx_pkg::ip_wait_length:
        if (wait_cnt == 3'd7)
          state_next = eth_tx_pkg::ip_gen_checksum;
      eth_tx_pkg::ip_gen_checksum:
        if (checksum_done)
          state_next = eth_tx_pkg::ip_send_wait;
      eth_tx_pkg::ip_send_wait:
        if (upper_tx_ready)
          state_next = eth_tx_pkg::ip_wait_mac;
        else if (timeout == eth_tx_pkg::send_timeout)
          state_next = eth_tx_pkg::ip_idle;
      eth_tx_pkg::ip_wait_mac:
        if (mac_data_req)
          state_next = eth_tx_pkg::ip_send;
        else if (timeout == eth_tx_pkg::send_timeout)
          state_next = eth_tx_pkg::ip_idle;
      eth_tx_pkg::ip_send:
        if (byte_cnt == last_idx)
          state_next = eth_tx_pkg::ip_idle;
      default:
        state_next = eth_tx_pkg::ip_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= eth_tx_pkg::ip_idle;
    else
      state <= state_next;
  end

  // frame fields frozen at start
  always_ff @(posedge clk)
  begin
    if ((state == eth_tx_pkg::ip_idle) && tx_start)
      cfg_q <= cfg;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      total_len_q    <= 16'd0;
      wait_cnt       <= 3'd0;
      byte_cnt       <= 16'd0;
      timeout        <= 16'd0;
      checksum_start <= 1'b0;
      ip_tx_ready    <= 1'b0;
      ip_tx_end      <= 1'b0;
      upper_data_req <= 1'b0;
    end
    else
    begin
      if ((state == eth_tx_pkg::ip_idle) && tx_start)
        total_len_q <= payload_len + eth_tx_pkg::ip_hdr_len;
      wait_cnt <= (state == eth_tx_pkg::ip_wait_length) ? wait_cnt + 3'd1 : 3'd0;
      byte_cnt <= (state == eth_tx_pkg::ip_send) ? byte_cnt + 16'd1 : 16'd0;
      // counts only while a wait state makes no progress
      if (((state == eth_tx_pkg::ip_send_wait) || (state == eth_tx_pkg::ip_wait_mac))
          && (state_next == state))
        timeout <= timeout + 16'd1;
      else
        timeout <= 16'd0;
      checksum_start <= (state == eth_tx_pkg::ip_wait_length) && (wait_cnt == 3'd7);
      ip_tx_ready    <= (state_next == eth_tx_pkg::ip_wait_mac);
      ip_tx_end      <= (state == eth_tx_pkg::ip_send) && (byte_cnt == last_idx);
      upper_data_req <= (state == eth_tx_pkg::ip_send) && (byte_cnt == 16'd30);
    end
  end

  // byte mux, registered one cycle behind the counter
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ip_tx_data <= 8'h00;
    else if (state != eth_tx_pkg::ip_send)
      ip_tx_data <= 8'h00;
    else if (byte_cnt < (eth_tx_pkg::eth_hdr_len + eth_tx_pkg::ip_hdr_len))
      ip_tx_data <= hdr[hdr_idx];
    else
      ip_tx_data <= upper_layer_data;
  end

endmodule

/* verilog/payload_buffer.sv */
// payload_buffer, host written byte store that feeds payload and padding to the framer
`timescale 1ns/1ps

module payload_buffer
#(
  parameter int PAYLOAD_DEPTH = 64
)
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr_en,
  input  logic [7:0]  wr_data,
  input  logic [15:0] payload_len,
  input  logic        busy,
  input  logic        upper_data_req,
  output logic        upper_tx_ready,
  output logic [7:0]  upper_layer_data
);

  localparam int addr_w = $clog2(PAYLOAD_DEPTH);

  logic [7:0]      mem [PAYLOAD_DEPTH];
  logic [addr_w:0] wr_cnt;
  logic [addr_w:0] wr_addr;
  logic            wr_ok;
  logic            busy_d;
  logic            busy_fall;
  logic [15:0]     len_q;
  logic            req_d;
  logic            rd_active;
  logic [15:0]     rd_cnt;

  assign busy_fall = busy_d && !busy;
  // a write in the cycle busy falls lands at address zero
  assign wr_addr   = busy_fall ? '0 : wr_cnt;
  assign wr_ok     = wr_en && !busy && (wr_addr != (addr_w + 1)'(PAYLOAD_DEPTH));

  assign upper_tx_ready = (16'(wr_cnt) >= payload_len);

  always_ff @(posedge clk)
  begin
    if (wr_ok)
      mem[wr_addr[addr_w-1:0]] <= wr_data;
  end

  ////////////////////////////////////////////////////////////
  // write pointer, length capture, read sequencing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_cnt    <= '0;
      busy_d    <= 1'b0;
      len_q     <= 16'd0;
      req_d     <= 1'b0;
      rd_active <= 1'b0;
      rd_cnt    <= 16'd0;
    end
    else
    begin
      busy_d <= busy;
      req_d  <= upper_data_req;
      if (busy_fall || wr_ok)
        wr_cnt <= wr_addr + (addr_w + 1)'(wr_ok);
      if (busy && !busy_d)
        len_q <= payload_len;
      if (!busy)
        rd_active <= 1'b0;
      else if (req_d)
        rd_active <= 1'b1;
      // byte 0 shows up three cycles after the request
      if (req_d)
        rd_cnt <= 16'd0;
      else if (rd_active)
        rd_cnt <= rd_cnt + 16'd1;
    end
  end

  // zeros past the stored length pad short frames
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      upper_layer_data <= 8'h00;
    else if (rd_active && (rd_cnt < len_q))
      upper_layer_data <= mem[rd_cnt[addr_w-1:0]];
    else
      upper_layer_data <= 8'h00;
  end

endmodule

/* verilog/ip_header_checksum.sv */
// ip_header_checksum, a four stage ones'-complement adder tree over the ipv4 header words
`timescale 1ns/1ps

module ip_header_checksum
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  eth_tx_pkg::ip_tx_cfg_t cfg,
  input  logic [15:0]            total_len,
  output logic [15:0]            checksum,
  output logic                   done
);

  logic [16:0] s1_a;
  logic [16:0] s1_b;
  logic [16:0] s1_c;
  logic [16:0] s1_d;
  logic [16:0] s1_e;
  logic [17:0] s2_a;
  logic [17:0] s2_b;
  logic [17:0] s2_c;
  logic [19:0] s3_sum;
  logic [16:0] fold1;
  logic [15:0] fold2;
  logic [2:0]  vld;

  // end around carry, folded twice
  assign fold1 = {1'b0, s3_sum[15:0]} + {13'd0, s3_sum[19:16]};
  assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

  // stage 1, word pairs; checksum field counts as zero
  always_ff @(posedge clk)
  begin
    s1_a <= {1'b0, eth_tx_pkg::ip_ver_ihl, 8'h00} + {1'b0, total_len};
    s1_b <= {1'b0, cfg.ident} + {1'b0, eth_tx_pkg::ip_flags_frag};
    s1_c <= {1'b0, cfg.ttl, cfg.protocol};
    s1_d <= {1'b0, cfg.src_ip[31:16]} + {1'b0, cfg.src_ip[15:0]};
    s1_e <= {1'b0, cfg.dst_ip[31:16]} + {1'b0, cfg.dst_ip[15:0]};
  end

  // stages 2 to 4
  always_ff @(posedge clk)
  begin
    s2_a     <= {1'b0, s1_a} + {1'b0, s1_b};
    s2_b     <= {1'b0, s1_c} + {1'b0, s1_d};
    s2_c     <= {1'b0, s1_e};
    s3_sum   <= {2'b00, s2_a} + {2'b00, s2_b} + {2'b00, s2_c};
    checksum <= ~fold2;
  end

  // valid travels alongside the sum, so starts may overlap
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vld  <= 3'b000;
      done <= 1'b0;
    end
    else
    begin
      vld  <= {vld[1:0], start};
      done <= vld[2];
    end
  end

endmodule

/* verilog/eth_tx_pkg.sv */
// frame addressing record, framer and mac state enums, ethernet and ipv4 constants
package eth_tx_pkg;

  ////////////////////////////////////////////////////////////
  // host supplied addressing, latched by the framer per frame
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [15:0] ident;
  } ip_tx_cfg_t;

  // ipv4 framer states
  typedef enum logic [2:0] {
    ip_idle         = 3'd0,
    ip_wait_length  = 3'd1,
    ip_gen_checksum = 3'd2,
    ip_send_wait    = 3'd3,
    ip_wait_mac     = 3'd4,
    ip_send         = 3'd5
  } ip_tx_state_e;

  // gmii side states
  typedef enum logic [2:0] {
    mac_idle     = 3'd0,
    mac_preamble = 3'd1,
    mac_frame    = 3'd2,
    mac_fcs      = 3'd3
  } mac_tx_state_e;

  ////////////////////////////////////////////////////////////
  // frame constants
  ////////////////////////////////////////////////////////////
  localparam logic [15:0] eth_type_ipv4 = 16'h0800;
  // version 4, five 32-bit header words
  localparam logic [7:0]  ip_ver_ihl    = 8'h45;
  // don't fragment, offset zero
  localparam logic [15:0] ip_flags_frag = 16'h4000;
  // shortest ip length that fills a minimum ethernet frame
  localparam logic [15:0] min_ip_len    = 16'd46;
  localparam logic [15:0] eth_hdr_len   = 16'd14;
  localparam logic [15:0] ip_hdr_len    = 16'd20;
  localparam logic [15:0] send_timeout  = 16'hFFFF;

endpackage
